//--- branch_ctrl_decode.sv
`timescale 1ns/100ps
`default_nettype none

module branch_ctrl_decode (
    input  cpu_pkg::word_t        instr,
    output cpu_pkg::branch_kind_t branch_kind,
    output cpu_pkg::jump_kind_t   jump_kind,
    output logic                  is_eret
);
    import cpu_pkg::*;

    opcode_t  opcode;
    reg_idx_t rt_field;
    funct_t   funct;

    assign opcode   = instr[31:26];
    assign rt_field = instr[20:16];
    assign funct    = instr[5:0];

    always_comb begin
        branch_kind = BK_NONE;
        jump_kind   = JK_NONE;
        is_eret     = 1'b0;
        case (opcode)
            OP_BEQ:  branch_kind = BK_EQ;
            OP_BNE:  branch_kind = BK_NE;
            OP_BLEZ: branch_kind = BK_LEZ;
            OP_BGTZ: branch_kind = BK_GTZ;
            OP_J:    jump_kind   = JK_IMM;
            OP_JAL:  jump_kind   = JK_IMM;

            OP_REGIMM: begin
                case (rt_field)
                    RT_BLTZ:   branch_kind = BK_LTZ;
                    RT_BGEZ:   branch_kind = BK_GEZ;
                    RT_BLTZAL: branch_kind = BK_LTZAL;
                    RT_BGEZAL: branch_kind = BK_GEZAL;
                    default:   branch_kind = BK_NONE;
                endcase
            end

            OP_SPECIAL: begin
                if ((funct == FN_JR) || (funct == FN_JALR)) begin
                    jump_kind = JK_REG;
                end
            end

            // ERET lives in the CO space of COP0.
            OP_COP0: begin
                is_eret = instr[25] && (funct == FN_ERET);
            end

            default: begin
                branch_kind = BK_NONE;
                jump_kind   = JK_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- branch_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

module branch_unit_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  cpu_pkg::word_t    in_pc,
    input  cpu_pkg::word_t    in_instr,
    input  cpu_pkg::word_t    in_rs_data,
    input  cpu_pkg::word_t    in_rt_data,
    input  cpu_pkg::word_t    cp0_epc,
    output logic              out_valid,
    input  logic              out_ready,
    output cpu_pkg::word_t    out_next_pc,
    output logic              out_redirect,
    output logic              out_delay_slot,
    output logic              out_exc,
    output cpu_pkg::reg_idx_t out_rs,
    output cpu_pkg::reg_idx_t out_rt,
    output cpu_pkg::reg_idx_t out_rd
);
    import cpu_pkg::*;

    fe_stream_if fe_bus ();

    logic     res_valid;
    logic     res_ready;
    word_t    res_next_pc;
    logic     res_redirect;
    logic     res_delay_slot;
    logic     res_exc;
    reg_idx_t res_rs;
    reg_idx_t res_rt;
    reg_idx_t res_rd;

    //////////////////////////////
    fe_capture u_capture (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_pc      (in_pc),
        .in_instr   (in_instr),
        .in_rs_data (in_rs_data),
        .in_rt_data (in_rt_data),
        .downstream (fe_bus.src)
    );

    next_pc_resolve u_resolve (
        .clk            (clk),
        .rst            (rst),
        .upstream       (fe_bus.dst),
        .cp0_epc        (cp0_epc),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_next_pc    (res_next_pc),
        .res_redirect   (res_redirect),
        .res_delay_slot (res_delay_slot),
        .res_exc        (res_exc),
        .res_rs         (res_rs),
        .res_rt         (res_rt),
        .res_rd         (res_rd)
    );

    result_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk            (clk),
        .rst            (rst),
        .wr_valid       (res_valid),
        .wr_ready       (res_ready),
        .wr_next_pc     (res_next_pc),
        .wr_redirect    (res_redirect),
        .wr_delay_slot  (res_delay_slot),
        .wr_exc         (res_exc),
        .wr_rs          (res_rs),
        .wr_rt          (res_rt),
        .wr_rd          (res_rd),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_next_pc    (out_next_pc),
        .out_redirect   (out_redirect),
        .out_delay_slot (out_delay_slot),
        .out_exc        (out_exc),
        .out_rs         (out_rs),
        .out_rt         (out_rt),
        .out_rd         (out_rd)
    );

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // Same eight conditions as the branch selector in decode, plus a no-branch value.
    typedef enum logic [3:0] {
        BK_NONE,
        BK_EQ,
        BK_NE,
        BK_LEZ,
        BK_GTZ,
        BK_LTZ,
        BK_GEZ,
        BK_LTZAL,
        BK_GEZAL
    } branch_kind_t;

    typedef enum logic [1:0] {
        JK_NONE,
        JK_IMM,   // J and JAL.
        JK_REG    // JR and JALR.
    } jump_kind_t;

    localparam word_t EXC_VECTOR = 32'hBFC0_0380;

    //////////////////////////////
    // Primary opcodes.
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_COP0    = 6'b010000;

    // REGIMM branches are told apart by the rt field.
    localparam reg_idx_t RT_BLTZ   = 5'b00000;
    localparam reg_idx_t RT_BGEZ   = 5'b00001;
    localparam reg_idx_t RT_BLTZAL = 5'b10000;
    localparam reg_idx_t RT_BGEZAL = 5'b10001;

    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_JALR = 6'b001001;
    localparam funct_t FN_ERET = 6'b011000;

endpackage

`default_nettype wire

//--- fe_capture.sv
`timescale 1ns/100ps
`default_nettype none

module fe_capture (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    output logic           in_ready,
    input  cpu_pkg::word_t in_pc,
    input  cpu_pkg::word_t in_instr,
    input  cpu_pkg::word_t in_rs_data,
    input  cpu_pkg::word_t in_rt_data,
    fe_stream_if.src       downstream
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {EMPTY, ONE, TWO} fill_t;

    fill_t state;
    fill_t state_next;
    word_t head_pc;
    word_t head_instr;
    word_t head_rs;
    word_t head_rt;
    word_t skid_pc;
    word_t skid_instr;
    word_t skid_rs;
    word_t skid_rt;
    logic  push;
    logic  pop;
    logic  load_head;
    logic  load_skid;
    logic  shift_skid;

    assign push = in_valid && in_ready;
    assign pop  = downstream.valid && downstream.ready;

    // The head entry is loaded directly when it is free or leaves in this cycle.
    assign load_head  = push && ((state == EMPTY) || ((state == ONE) && pop));
    assign load_skid  = push && (state == ONE) && !pop;
    assign shift_skid = pop && (state == TWO);

    always_comb begin
        state_next = state;
        case (state)
            EMPTY: begin
                if (push) state_next = ONE;
            end
            ONE: begin
                if (push && !pop) state_next = TWO;
                else if (pop && !push) state_next = EMPTY;
            end
            TWO: begin
                if (pop) state_next = ONE;
            end
            default: state_next = EMPTY;
        endcase
    end

    // Ready is registered, so a downstream stall never reaches in_ready in the same cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= EMPTY;
            in_ready <= 1'b0;
        end else begin
            state    <= state_next;
            in_ready <= (state_next != TWO);
        end
    end

    always_ff @(posedge clk) begin
        if (load_head) begin
            head_pc    <= in_pc;
            head_instr <= in_instr;
            head_rs    <= in_rs_data;
            head_rt    <= in_rt_data;
        end else if (shift_skid) begin
            head_pc    <= skid_pc;
            head_instr <= skid_instr;
            head_rs    <= skid_rs;
            head_rt    <= skid_rt;
        end
        if (load_skid) begin
            skid_pc    <= in_pc;
            skid_instr <= in_instr;
            skid_rs    <= in_rs_data;
            skid_rt    <= in_rt_data;
        end
    end

    assign downstream.valid    = (state != EMPTY);
    assign downstream.pc       = head_pc;
    assign downstream.instr    = head_instr;
    assign downstream.rs_data  = head_rs;
    assign downstream.rt_data  = head_rt;
    assign downstream.addr_err = |head_pc[1:0];

    a_hold_stable : assert property (@(posedge clk) disable iff (rst)
        downstream.valid && !downstream.ready |=>
            downstream.valid && $stable(downstream.pc) && $stable(downstream.instr)
            && $stable(downstream.rs_data) && $stable(downstream.rt_data));

endmodule

`default_nettype wire

//--- fe_stream_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fe_stream_if;
    import cpu_pkg::*;

    logic  valid;
    logic  ready;
    word_t pc;
    word_t instr;
    word_t rs_data;
    word_t rt_data;
    logic  addr_err;   // Fetch address was not word aligned.

    modport src (
        output valid, pc, instr, rs_data, rt_data, addr_err,
        input  ready
    );

    modport dst (
        input  valid, pc, instr, rs_data, rt_data, addr_err,
        output ready
    );

endinterface

`default_nettype wire

//--- next_pc_resolve.sv
`timescale 1ns/100ps
`default_nettype none

module next_pc_resolve (
    input  logic              clk,
    input  logic              rst,
    fe_stream_if.dst          upstream,
    input  cpu_pkg::word_t    cp0_epc,
    output logic              res_valid,
    input  logic              res_ready,
    output cpu_pkg::word_t    res_next_pc,
    output logic              res_redirect,
    output logic              res_delay_slot,
    output logic              res_exc,
    output cpu_pkg::reg_idx_t res_rs,
    output cpu_pkg::reg_idx_t res_rt,
    output cpu_pkg::reg_idx_t res_rd
);
    import cpu_pkg::*;

    branch_kind_t branch_kind;
    jump_kind_t   jump_kind;
    logic         is_eret;
    word_t        rs;
    word_t        pc_plus4;
    word_t        sign_imm;
    word_t        branch_target;
    word_t        jump_target;
    word_t        next_pc;
    logic         rs_eq_rt;
    logic         rs_zero;
    logic         rs_gtz;
    logic         taken;
    logic         accept;

    branch_ctrl_decode u_decode (
        .instr       (upstream.instr),
        .branch_kind (branch_kind),
        .jump_kind   (jump_kind),
        .is_eret     (is_eret)
    );

    assign upstream.ready = !res_valid || res_ready;
    assign accept         = upstream.valid && upstream.ready;

    //////////////////////////////
    // Branch conditions.
    assign rs       = upstream.rs_data;
    assign rs_eq_rt = (rs == upstream.rt_data);
    assign rs_zero  = (rs == '0);
    assign rs_gtz   = !rs[31] && !rs_zero;

    always_comb begin
        case (branch_kind)
            BK_EQ:    taken = rs_eq_rt;
            BK_NE:    taken = !rs_eq_rt;
            BK_LEZ:   taken = !rs_gtz;
            BK_GTZ:   taken = rs_gtz;
            BK_LTZ:   taken = !rs_gtz && !rs_zero;
            BK_LTZAL: taken = !rs_gtz && !rs_zero;
            BK_GEZ:   taken = rs_gtz || rs_zero;
            BK_GEZAL: taken = rs_gtz || rs_zero;
            default:  taken = 1'b0;
        endcase
    end

    //////////////////////////////
    // Target selection.
    assign pc_plus4      = upstream.pc + 32'd4;
    assign sign_imm      = {{16{upstream.instr[15]}}, upstream.instr[15:0]};
    assign branch_target = pc_plus4 + {sign_imm[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], upstream.instr[25:0], 2'b00};

    always_comb begin
        if (upstream.addr_err) begin
            next_pc = EXC_VECTOR;   // A bad fetch beats whatever the word decodes to.
        end else if (is_eret) begin
            next_pc = cp0_epc;
        end else if (jump_kind == JK_REG) begin
            next_pc = rs;
        end else if (jump_kind == JK_IMM) begin
            next_pc = jump_target;
        end else if (taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (accept) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_next_pc    <= next_pc;
            res_redirect   <= (next_pc != pc_plus4);
            res_delay_slot <= (branch_kind != BK_NONE) || (jump_kind != JK_NONE);
            res_exc        <= upstream.addr_err;
            res_rs         <= upstream.instr[25:21];
            res_rt         <= upstream.instr[20:16];
            res_rd         <= upstream.instr[15:11];
        end
    end

    a_valid_held : assert property (@(posedge clk) disable iff (rst)
        $fell(res_valid) |-> $past(res_ready));

endmodule

`default_nettype wire

//--- result_queue.sv
`timescale 1ns/100ps
`default_nettype none

module result_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_valid,
    output logic              wr_ready,
    input  cpu_pkg::word_t    wr_next_pc,
    input  logic              wr_redirect,
    input  logic              wr_delay_slot,
    input  logic              wr_exc,
    input  cpu_pkg::reg_idx_t wr_rs,
    input  cpu_pkg::reg_idx_t wr_rt,
    input  cpu_pkg::reg_idx_t wr_rd,
    output logic              out_valid,
    input  logic              out_ready,
    output cpu_pkg::word_t    out_next_pc,
    output logic              out_redirect,
    output logic              out_delay_slot,
    output logic              out_exc,
    output cpu_pkg::reg_idx_t out_rs,
    output cpu_pkg::reg_idx_t out_rt,
    output cpu_pkg::reg_idx_t out_rd
);
    import cpu_pkg::*;

    localparam int PTR_W   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W   = $clog2(QUEUE_DEPTH + 1);
    localparam int ENTRY_W = $bits(word_t) + 3 + 3 * $bits(reg_idx_t);

    logic [ENTRY_W-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               wr_en;
    logic               rd_en;

    assign wr_ready  = (count < CNT_W'(QUEUE_DEPTH));
    assign out_valid = (count != '0);
    assign wr_en     = wr_valid && wr_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {wr_next_pc, wr_redirect, wr_delay_slot, wr_exc,
                            wr_rs, wr_rt, wr_rd};
        end
    end

    // Pointers wrap explicitly so any depth works, not only powers of two.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) count <= count + 1'b1;
            else if (rd_en && !wr_en) count <= count - 1'b1;
        end
    end

    assign {out_next_pc, out_redirect, out_delay_slot, out_exc,
            out_rs, out_rt, out_rd} = mem[rd_ptr];

    // Equal pointers with a non-zero count means every slot is taken.
    a_no_write_full : assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !((wr_ptr == rd_ptr) && (count != '0)));

    // Equal pointers below a full count mean the queue is empty.
    a_no_read_empty : assert property (@(posedge clk) disable iff (rst)
        rd_en |-> ((wr_ptr != rd_ptr) || (count == CNT_W'(QUEUE_DEPTH))));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the branch unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_branch_unit -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_branch_unit)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- sim.f
cpu_pkg.sv
fe_stream_if.sv
branch_ctrl_decode.sv
fe_capture.sv
next_pc_resolve.sv
result_queue.sv
branch_unit_top.sv
tb_checker.sv
tb_branch_unit.sv

//--- tb_branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_branch_unit;
    import cpu_pkg::*;

    localparam int NUM_KINDS     = 17;
    localparam int SEND_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT = 1000;

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    word_t    in_pc;
    word_t    in_instr;
    word_t    in_rs_data;
    word_t    in_rt_data;
    word_t    cp0_epc;
    logic     out_valid;
    logic     out_ready;
    word_t    out_next_pc;
    logic     out_redirect;
    logic     out_delay_slot;
    logic     out_exc;
    reg_idx_t out_rs;
    reg_idx_t out_rt;
    reg_idx_t out_rd;
    int       error_count;
    int       pending;
    int       checked;
    integer   seed = 11;
    int       stall_level;
    logic     timed_out;

    always #20 clk = ~clk;

    branch_unit_top #(.QUEUE_DEPTH(4)) UUT (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
        .in_pc(in_pc), .in_instr(in_instr), .in_rs_data(in_rs_data),
        .in_rt_data(in_rt_data), .cp0_epc(cp0_epc), .out_valid(out_valid),
        .out_ready(out_ready), .out_next_pc(out_next_pc), .out_redirect(out_redirect),
        .out_delay_slot(out_delay_slot), .out_exc(out_exc), .out_rs(out_rs),
        .out_rt(out_rt), .out_rd(out_rd)
    );

    tb_checker u_check (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
        .in_pc(in_pc), .in_instr(in_instr), .in_rs_data(in_rs_data),
        .in_rt_data(in_rt_data), .cp0_epc(cp0_epc), .out_valid(out_valid),
        .out_ready(out_ready), .out_next_pc(out_next_pc), .out_redirect(out_redirect),
        .out_delay_slot(out_delay_slot), .out_exc(out_exc), .out_rs(out_rs),
        .out_rt(out_rt), .out_rd(out_rd), .error_count(error_count),
        .pending(pending), .checked(checked)
    );

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Every wait goes through here, so out_ready changes once per clock.
    task automatic next_cycle();
        @(posedge clk);
        out_ready <= (rand_below(4) >= stall_level);
    endtask

    task automatic send_item(input word_t pc, input word_t instr, input word_t rs_val,
                             input word_t rt_val);
        int   waited;
        logic done;
        if (!timed_out) begin
            in_valid   <= 1'b1;
            in_pc      <= pc;
            in_instr   <= instr;
            in_rs_data <= rs_val;
            in_rt_data <= rt_val;
            waited = 0;
            done   = 1'b0;
            while (!done && !timed_out) begin
                next_cycle();
                if (in_ready) begin
                    done = 1'b1;   // Value seen before the edge, so the item moved here.
                end else begin
                    waited++;
                    if (waited >= SEND_TIMEOUT) begin
                        $display("Timeout: in_ready stayed low for %0d cycles", waited);
                        timed_out = 1'b1;
                    end
                end
            end
            in_valid <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        if (!timed_out) begin
            waited = 0;
            next_cycle();
            while ((pending != 0) && !timed_out) begin
                next_cycle();
                waited++;
                if (waited >= DRAIN_TIMEOUT) begin
                    $display("Timeout: %0d results still pending after %0d cycles",
                             pending, waited);
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    function automatic word_t pick_pc(input logic misaligned);
        word_t pc;
        pc = rand_word() & 32'hFFFF_FFFC;
        if (misaligned) pc = pc | word_t'(1 + rand_below(3));
        return pc;
    endfunction

    //////////////////////////////
    // Kinds 0 to 12 are control transfers, the rest look similar but are not.
    function automatic word_t build_instr(input int kind);
        word_t r;
        r = rand_word();
        case (kind)
            0:  return {OP_BEQ, r[25:0]};
            1:  return {OP_BNE, r[25:0]};
            2:  return {OP_BLEZ, r[25:21], 5'b00000, r[15:0]};
            3:  return {OP_BGTZ, r[25:21], 5'b00000, r[15:0]};
            4:  return {OP_REGIMM, r[25:21], RT_BLTZ, r[15:0]};
            5:  return {OP_REGIMM, r[25:21], RT_BGEZ, r[15:0]};
            6:  return {OP_REGIMM, r[25:21], RT_BLTZAL, r[15:0]};
            7:  return {OP_REGIMM, r[25:21], RT_BGEZAL, r[15:0]};
            8:  return {OP_J, r[25:0]};
            9:  return {OP_JAL, r[25:0]};
            10: return {OP_SPECIAL, r[25:21], 15'd0, FN_JR};
            11: return {OP_SPECIAL, r[25:21], 5'b00000, r[15:11], 5'b00000, FN_JALR};
            12: return {OP_COP0, 1'b1, 19'd0, FN_ERET};
            13: return {OP_SPECIAL, r[25:6], 6'b100001};   // ADDU.
            14: return {6'b001101, r[25:0]};               // ORI.
            15: return {OP_REGIMM, r[25:21], 5'b00010, r[15:0]};
            default: return {OP_COP0, 1'b0, r[24:6], FN_ERET};
        endcase
    endfunction

    // Modes cover equal, unequal, zero, negative and positive rs.
    task automatic pick_operands(input int mode, output word_t rs_val, output word_t rt_val);
        rt_val = rand_word();
        case (mode)
            0:       rs_val = rt_val;
            1:       rs_val = rt_val ^ (rand_word() | 32'h1);
            2:       rs_val = '0;
            3:       rs_val = rand_word() | 32'h8000_0000;
            default: rs_val = (rand_word() & 32'h7FFF_FFFF) | 32'h1;
        endcase
    endtask

    initial begin
        word_t rs_val;
        word_t rt_val;
        int    i;
        int    k;
        int    m;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_pc       = '0;
        in_instr    = '0;
        in_rs_data  = '0;
        in_rt_data  = '0;
        cp0_epc     = 32'h8000_0180;
        out_ready   = 1'b0;
        stall_level = 1;
        timed_out   = 1'b0;
        repeat (16) next_cycle();
        rst <= 1'b0;

        // Every kind against every operand mode.
        for (k = 0; k < NUM_KINDS; k++) begin
            for (m = 0; m < 5; m++) begin
                pick_operands(m, rs_val, rt_val);
                send_item(pick_pc(1'b0), build_instr(k), rs_val, rt_val);
            end
        end
        wait_drain();

        for (k = 0; k < NUM_KINDS; k++) begin
            pick_operands(rand_below(5), rs_val, rt_val);
            send_item(pick_pc(1'b1), build_instr(k), rs_val, rt_val);
        end
        wait_drain();

        for (i = 0; i < 3; i++) begin
            cp0_epc <= rand_word();
            for (k = 0; k < 4; k++) begin
                pick_operands(rand_below(5), rs_val, rt_val);
                send_item(pick_pc(k == 3), build_instr(12), rs_val, rt_val);
            end
            wait_drain();
        end

        //////////////////////////////
        for (k = 0; k < 3; k++) begin
            stall_level = (k == 0) ? 0 : k + 1;
            for (i = 0; i < 150; i++) begin
                if (rand_below(4) == 0) next_cycle();
                pick_operands(rand_below(5), rs_val, rt_val);
                m = rand_below(NUM_KINDS);
                send_item(pick_pc(rand_below(8) == 0), build_instr(m), rs_val, rt_val);
            end
            wait_drain();
        end

        // One more edge, so the counts also cover the last cycle of the drain.
        next_cycle();

        if (pending != 0) begin
            $display("%0d expected results never came out of the DUT", pending);
        end
        $display("Checked %0d results, %0d errors, %0d missing, timeout %0d",
                 checked, error_count, pending, timed_out);
        if ((error_count == 0) && (pending == 0) && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic              in_ready,
    input  cpu_pkg::word_t    in_pc,
    input  cpu_pkg::word_t    in_instr,
    input  cpu_pkg::word_t    in_rs_data,
    input  cpu_pkg::word_t    in_rt_data,
    input  cpu_pkg::word_t    cp0_epc,
    input  logic              out_valid,
    input  logic              out_ready,
    input  cpu_pkg::word_t    out_next_pc,
    input  logic              out_redirect,
    input  logic              out_delay_slot,
    input  logic              out_exc,
    input  cpu_pkg::reg_idx_t out_rs,
    input  cpu_pkg::reg_idx_t out_rt,
    input  cpu_pkg::reg_idx_t out_rd,
    output int                error_count,
    output int                pending,
    output int                checked
);
    import cpu_pkg::*;

    typedef struct packed {
        word_t    next_pc;
        logic     redirect;
        logic     delay_slot;
        logic     exc;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
    } result_t;

    result_t exp_q[$];
    result_t exp_r;
    result_t got_r;
    int      errs = 0;
    int      seen = 0;

    // Expected result of one instruction, from the MIPS next-PC rules.
    function automatic result_t next_pc_model(word_t pc, word_t instr, word_t rs_val,
                                              word_t rt_val, word_t epc);
        result_t r;
        word_t   seq;
        word_t   target;
        logic    is_branch;
        logic    cond;
        logic    is_jimm;
        logic    is_jreg;
        logic    is_eret;
        seq       = pc + 32'd4;
        is_branch = 1'b0;
        cond      = 1'b0;
        is_jimm   = 1'b0;
        is_jreg   = 1'b0;
        is_eret   = 1'b0;
        case (instr[31:26])
            OP_BEQ: begin
                is_branch = 1'b1;
                cond      = (rs_val == rt_val);
            end
            OP_BNE: begin
                is_branch = 1'b1;
                cond      = (rs_val != rt_val);
            end
            OP_BLEZ: begin
                is_branch = 1'b1;
                cond      = ($signed(rs_val) <= 0);
            end
            OP_BGTZ: begin
                is_branch = 1'b1;
                cond      = ($signed(rs_val) > 0);
            end
            OP_REGIMM: begin
                case (instr[20:16])
                    RT_BLTZ, RT_BLTZAL: begin
                        is_branch = 1'b1;
                        cond      = ($signed(rs_val) < 0);
                    end
                    RT_BGEZ, RT_BGEZAL: begin
                        is_branch = 1'b1;
                        cond      = ($signed(rs_val) >= 0);
                    end
                    default: ;
                endcase
            end
            OP_J, OP_JAL: is_jimm = 1'b1;
            OP_SPECIAL:   is_jreg = (instr[5:0] == FN_JR) || (instr[5:0] == FN_JALR);
            OP_COP0:      is_eret = instr[25] && (instr[5:0] == FN_ERET);
            default: ;
        endcase
        if (pc[1:0] != 2'b00) target = EXC_VECTOR;
        else if (is_eret) target = epc;
        else if (is_jreg) target = rs_val;
        else if (is_jimm) target = {seq[31:28], instr[25:0], 2'b00};
        else if (is_branch && cond) target = seq + {{14{instr[15]}}, instr[15:0], 2'b00};
        else target = seq;
        r.next_pc    = target;
        r.redirect   = (target != seq);
        r.delay_slot = is_branch || is_jimm || is_jreg;   // Taken or not.
        r.exc        = (pc[1:0] != 2'b00);
        r.rs         = instr[25:21];
        r.rt         = instr[20:16];
        r.rd         = instr[15:11];
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
        if (got_v !== exp_v) begin
            $display("ERROR %0t: %s expected %h, got %h", $time, name, exp_v, got_v);
            errs++;
        end
    endtask

    //////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            if ((in_ready === 1'b1) || (out_valid === 1'b1)) begin
                $display("in_ready or out_valid was high during reset at %0t", $time);
                errs++;
            end
        end else begin
            if (out_valid && (exp_q.size() == 0)) begin
                $display("The DUT showed a result at %0t with no instruction pending",
                         $time);
                errs++;
            end else if (out_valid && out_ready) begin
                got_r.next_pc    = out_next_pc;
                got_r.redirect   = out_redirect;
                got_r.delay_slot = out_delay_slot;
                got_r.exc        = out_exc;
                got_r.rs         = out_rs;
                got_r.rt         = out_rt;
                got_r.rd         = out_rd;
                exp_r = exp_q.pop_front();
                check_field("next_pc", exp_r.next_pc, got_r.next_pc);
                check_field("redirect", exp_r.redirect, got_r.redirect);
                check_field("delay_slot", exp_r.delay_slot, got_r.delay_slot);
                check_field("exc", exp_r.exc, got_r.exc);
                check_field("rs", exp_r.rs, got_r.rs);
                check_field("rt", exp_r.rt, got_r.rt);
                check_field("rd", exp_r.rd, got_r.rd);
                seen++;
            end
            // EPC only changes while nothing is in flight.
            if (in_valid && in_ready) begin
                exp_q.push_back(next_pc_model(in_pc, in_instr, in_rs_data, in_rt_data,
                                              cp0_epc));
            end
        end
        error_count <= errs;
        pending     <= exp_q.size();
        checked     <= seen;
    end

endmodule

`default_nettype wire
